/* verilog/mpsoc_cfg.svh */
`ifndef MPSOC_CFG_SVH
`define MPSOC_CFG_SVH

// Number of tiles on the shared link
`define MPSOC_NODES 4

// Flit payload width in bits
`define MPSOC_DATA_W 32

// Entries in every injection and event FIFO
`define MPSOC_FIFO_DEPTH 4

// Longest packet in flits
`define MPSOC_MAX_PKT_LEN 8

`endif

/* verilog/mpsoc_pkg.sv */
`include "mpsoc_cfg.svh"

package mpsoc_pkg;

  // Tile index
  typedef logic [1:0] node_id_t;

  // One flit on the link, source stamped by the sender
  typedef struct packed {
    node_id_t                  dest;
    node_id_t                  src;
    logic                      last;  // Final flit of the packet
    logic [`MPSOC_DATA_W-1:0]  data;
  } flit_t;

  // Reported once per sent packet
  typedef struct packed {
    node_id_t   src;
    node_id_t   dest;
    logic [3:0] len;  // Flits in the packet
  } dbg_event_t;

endpackage

/* verilog/flit_fifo.sv */
module flit_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = 4
) (
  input  logic clk,
  input  logic rst_n_i,
  input  logic in_valid_i,
  input  T     in_data_i,
  output logic in_ready_o,
  output logic out_valid_o,
  output T     out_data_o,
  input  logic out_ready_i
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  assign out_valid_o = (count != '0);
  assign in_ready_o  = (count != CNT_W'(DEPTH)) || out_ready_i;  // Full, but popping
  assign out_data_o  = mem[rd_ptr];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  a_count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
    count <= CNT_W'(DEPTH));

  // Head entry must not move under a stalled consumer
  a_out_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

/* verilog/noc_tile.sv */
`include "mpsoc_cfg.svh"

module noc_tile import mpsoc_pkg::*; #(
  parameter node_id_t NODE_ID = 2'd0
) (
  input  logic                     clk,
  input  logic                     rst_n_i,

  input  logic                     inj_valid_i,
  input  node_id_t                 inj_dest_i,
  input  logic [`MPSOC_DATA_W-1:0] inj_data_i,
  input  logic                     inj_last_i,
  output logic                     inj_ready_o,

  output logic                     req_valid_o,
  output flit_t                    req_flit_o,
  input  logic                     req_ready_i,

  input  logic                     dlv_valid_i,
  input  flit_t                    dlv_flit_i,
  output logic                     dlv_ready_o,

  output logic                     rx_valid_o,
  output node_id_t                 rx_src_o,
  output logic [`MPSOC_DATA_W-1:0] rx_data_o,
  output logic                     rx_last_o,
  input  logic                     rx_ready_i,

  input  logic                     ring_in_valid_i,
  input  dbg_event_t               ring_in_event_i,
  output logic                     ring_in_ready_o,
  output logic                     ring_out_valid_o,
  output dbg_event_t               ring_out_event_o,
  input  logic                     ring_out_ready_i
);

  localparam int CNT_W = $clog2(`MPSOC_MAX_PKT_LEN + 1);

  flit_t      inj_flit;
  logic       fifo_valid;
  flit_t      fifo_flit;
  logic       send;
  logic       pkt_start;
  logic [CNT_W-1:0] pkt_cnt;  // Flits already sent of the current packet

  dbg_event_t evt_q;
  logic       evt_valid_q;
  logic       evt_in_ready;
  logic       evt_room;
  logic       evt_out_valid;
  dbg_event_t evt_out;
  logic       evt_out_ready;
  logic       sel_own;
  logic       own_hold_q;

  always_comb begin
    inj_flit      = '0;
    inj_flit.dest = inj_dest_i;
    inj_flit.src  = NODE_ID;
    inj_flit.last = inj_last_i;
    inj_flit.data = inj_data_i;
  end

  flit_fifo #(
    .T     (flit_t),
    .DEPTH (`MPSOC_FIFO_DEPTH)
  ) i_inj_fifo (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (inj_valid_i),
    .in_data_i   (inj_flit),
    .in_ready_o  (inj_ready_o),
    .out_valid_o (fifo_valid),
    .out_data_o  (fifo_flit),
    .out_ready_i (send)
  );

  // A new packet only starts when its event is sure to find a slot
  assign pkt_start   = (pkt_cnt == '0);
  assign evt_room    = evt_in_ready && !evt_valid_q;
  assign req_valid_o = fifo_valid && (!pkt_start || evt_room);
  assign req_flit_o  = fifo_flit;
  assign send        = req_valid_o && req_ready_i;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pkt_cnt     <= '0;
      evt_valid_q <= 1'b0;
    end else begin
      evt_valid_q <= send && fifo_flit.last;
      if (send) begin
        pkt_cnt <= fifo_flit.last ? '0 : pkt_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send && fifo_flit.last) begin
      evt_q.src  <= NODE_ID;
      evt_q.dest <= fifo_flit.dest;
      evt_q.len  <= 4'(pkt_cnt + 1'b1);
    end
  end

  flit_fifo #(
    .T     (dbg_event_t),
    .DEPTH (`MPSOC_FIFO_DEPTH)
  ) i_evt_fifo (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (evt_valid_q),
    .in_data_i   (evt_q),
    .in_ready_o  (evt_in_ready),
    .out_valid_o (evt_out_valid),
    .out_data_o  (evt_out),
    .out_ready_i (evt_out_ready)
  );

  // Receive path is a straight pass-through
  assign rx_valid_o  = dlv_valid_i;
  assign rx_src_o    = dlv_flit_i.src;
  assign rx_data_o   = dlv_flit_i.data;
  assign rx_last_o   = dlv_flit_i.last;
  assign dlv_ready_o = rx_ready_i;

  // Upstream wins unless our own event is already on the ring output
  assign sel_own          = evt_out_valid && (!ring_in_valid_i || own_hold_q);
  assign ring_out_valid_o = ring_in_valid_i || evt_out_valid;
  assign ring_out_event_o = sel_own ? evt_out : ring_in_event_i;
  assign ring_in_ready_o  = ring_out_ready_i && !sel_own;
  assign evt_out_ready    = ring_out_ready_i && sel_own;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      own_hold_q <= 1'b0;
    end else begin
      own_hold_q <= sel_own && !ring_out_ready_i;  // Keep offer stable
    end
  end

  a_pkt_len: assert property (@(posedge clk) disable iff (!rst_n_i)
    pkt_cnt < CNT_W'(`MPSOC_MAX_PKT_LEN));

  a_evt_no_drop: assert property (@(posedge clk) disable iff (!rst_n_i)
    evt_valid_q |-> evt_in_ready);

endmodule

/* verilog/noc_link_arbiter.sv */
`include "mpsoc_cfg.svh"

module noc_link_arbiter import mpsoc_pkg::*; (
  input  logic                      clk,
  input  logic                      rst_n_i,

  input  logic  [`MPSOC_NODES-1:0]  req_valid_i,
  input  flit_t [`MPSOC_NODES-1:0]  req_flit_i,
  output logic  [`MPSOC_NODES-1:0]  req_ready_o,

  output logic  [`MPSOC_NODES-1:0]  dlv_valid_o,
  output flit_t                     dlv_flit_o,
  input  logic  [`MPSOC_NODES-1:0]  dlv_ready_i
);

  localparam int NODES = `MPSOC_NODES;

  logic             out_valid_q;
  flit_t            out_flit_q;
  node_id_t         rr_ptr_q;   // Highest priority requester
  logic             locked_q;   // Packet in progress
  node_id_t         lock_id_q;
  logic [NODES-1:0] grant;
  node_id_t         win_id;
  node_id_t         idx;
  logic             can_accept;
  logic             accept;

  // Output register frees up when its flit leaves this cycle
  assign can_accept = !out_valid_q || dlv_ready_i[out_flit_q.dest];

  always_comb begin
    grant  = '0;
    win_id = rr_ptr_q;
    idx    = rr_ptr_q;
    if (locked_q) begin
      win_id = lock_id_q;
    end else begin
      // Walk backwards so the closest requester after the pointer wins
      for (int k = NODES - 1; k >= 0; k--) begin
        idx = rr_ptr_q + node_id_t'(k);
        if (req_valid_i[idx]) begin
          win_id = idx;
        end
      end
    end
    grant[win_id] = req_valid_i[win_id];
  end

  assign req_ready_o = grant & {NODES{can_accept}};
  assign accept      = |grant && can_accept;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
      rr_ptr_q    <= '0;
      locked_q    <= 1'b0;
      lock_id_q   <= '0;
    end else begin
      if (can_accept) begin
        out_valid_q <= accept;
      end
      if (accept) begin
        if (req_flit_i[win_id].last) begin
          locked_q <= 1'b0;
          rr_ptr_q <= win_id + 1'b1;
        end else begin
          locked_q  <= 1'b1;
          lock_id_q <= win_id;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_flit_q <= req_flit_i[win_id];
    end
  end

  // Destination decode of the registered flit
  always_comb begin
    dlv_valid_o = '0;
    dlv_valid_o[out_flit_q.dest] = out_valid_q;
  end
  assign dlv_flit_o = out_flit_q;

  a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n_i)
    !locked_q && (req_valid_i != '0) |-> $onehot(grant));

  a_grant_locked: assert property (@(posedge clk) disable iff (!rst_n_i)
    accept && !req_flit_i[win_id].last |=> (grant == '0) || (grant == $past(grant)));

endmodule

/* verilog/mpsoc_top.sv */
`include "mpsoc_cfg.svh"

module mpsoc_top import mpsoc_pkg::*; (
  input  logic                                          clk,
  input  logic                                          rst_n_i,

  input  logic     [`MPSOC_NODES-1:0]                   inj_valid_i,
  input  node_id_t [`MPSOC_NODES-1:0]                   inj_dest_i,
  input  logic     [`MPSOC_NODES-1:0][`MPSOC_DATA_W-1:0] inj_data_i,
  input  logic     [`MPSOC_NODES-1:0]                   inj_last_i,
  output logic     [`MPSOC_NODES-1:0]                   inj_ready_o,

  output logic     [`MPSOC_NODES-1:0]                   rx_valid_o,
  output node_id_t [`MPSOC_NODES-1:0]                   rx_src_o,
  output logic     [`MPSOC_NODES-1:0][`MPSOC_DATA_W-1:0] rx_data_o,
  output logic     [`MPSOC_NODES-1:0]                   rx_last_o,
  input  logic     [`MPSOC_NODES-1:0]                   rx_ready_i,

  output logic                                          dbg_valid_o,
  output dbg_event_t                                    dbg_event_o,
  input  logic                                          dbg_ready_i
);

  localparam int NODES = `MPSOC_NODES;

  // Tiles <-> shared link
  logic  [NODES-1:0] req_valid;
  flit_t [NODES-1:0] req_flit;
  logic  [NODES-1:0] req_ready;
  logic  [NODES-1:0] dlv_valid;
  flit_t             dlv_flit;
  logic  [NODES-1:0] dlv_ready;

  // Debug ring
  logic       [NODES-1:0] ring_in_valid;
  dbg_event_t [NODES-1:0] ring_in_event;
  logic       [NODES-1:0] ring_in_ready;
  logic       [NODES-1:0] ring_out_valid;
  dbg_event_t [NODES-1:0] ring_out_event;
  logic       [NODES-1:0] ring_out_ready;

  assign ring_in_valid[0] = 1'b0;  // Head of the ring
  assign ring_in_event[0] = '0;

  // Meander order 0 -> 1 -> 3 -> 2
  assign ring_in_valid[1]  = ring_out_valid[0];
  assign ring_in_event[1]  = ring_out_event[0];
  assign ring_out_ready[0] = ring_in_ready[1];
  assign ring_in_valid[3]  = ring_out_valid[1];
  assign ring_in_event[3]  = ring_out_event[1];
  assign ring_out_ready[1] = ring_in_ready[3];
  assign ring_in_valid[2]  = ring_out_valid[3];
  assign ring_in_event[2]  = ring_out_event[3];
  assign ring_out_ready[3] = ring_in_ready[2];

  assign dbg_valid_o       = ring_out_valid[2];
  assign dbg_event_o       = ring_out_event[2];
  assign ring_out_ready[2] = dbg_ready_i;

  noc_link_arbiter i_link_arbiter (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid),
    .req_flit_i  (req_flit),
    .req_ready_o (req_ready),
    .dlv_valid_o (dlv_valid),
    .dlv_flit_o  (dlv_flit),
    .dlv_ready_i (dlv_ready)
  );

  for (genvar i = 0; i < NODES; i++) begin : gen_tile
    noc_tile #(
      .NODE_ID (node_id_t'(i))
    ) i_noc_tile (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .inj_valid_i      (inj_valid_i[i]),
      .inj_dest_i       (inj_dest_i[i]),
      .inj_data_i       (inj_data_i[i]),
      .inj_last_i       (inj_last_i[i]),
      .inj_ready_o      (inj_ready_o[i]),
      .req_valid_o      (req_valid[i]),
      .req_flit_o       (req_flit[i]),
      .req_ready_i      (req_ready[i]),
      .dlv_valid_i      (dlv_valid[i]),
      .dlv_flit_i       (dlv_flit),
      .dlv_ready_o      (dlv_ready[i]),
      .rx_valid_o       (rx_valid_o[i]),
      .rx_src_o         (rx_src_o[i]),
      .rx_data_o        (rx_data_o[i]),
      .rx_last_o        (rx_last_o[i]),
      .rx_ready_i       (rx_ready_i[i]),
      .ring_in_valid_i  (ring_in_valid[i]),
      .ring_in_event_i  (ring_in_event[i]),
      .ring_in_ready_o  (ring_in_ready[i]),
      .ring_out_valid_o (ring_out_valid[i]),
      .ring_out_event_o (ring_out_event[i]),
      .ring_out_ready_i (ring_out_ready[i])
    );
  end

endmodule

/* tb/tb_mpsoc.sv */
`include "mpsoc_cfg.svh"

module tb_mpsoc import mpsoc_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NODES          = `MPSOC_NODES;
  localparam int MAX_LEN        = `MPSOC_MAX_PKT_LEN;
  localparam int PERIOD         = 100;
  localparam int NUM_PKTS       = 40;    // Per tile and per traffic test
  localparam int TIMEOUT_CYCLES = 5000;

  logic                                 clk;
  logic                                 rst_n;
  logic     [NODES-1:0]                 inj_valid;
  node_id_t [NODES-1:0]                 inj_dest;
  logic     [NODES-1:0][`MPSOC_DATA_W-1:0] inj_data;
  logic     [NODES-1:0]                 inj_last;
  logic     [NODES-1:0]                 inj_ready;
  logic     [NODES-1:0]                 rx_valid;
  node_id_t [NODES-1:0]                 rx_src;
  logic     [NODES-1:0][`MPSOC_DATA_W-1:0] rx_data;
  logic     [NODES-1:0]                 rx_last;
  logic     [NODES-1:0]                 rx_ready;
  logic                                 dbg_valid;
  dbg_event_t                           dbg_event;
  logic                                 dbg_ready;

  // Reference model of expected flits per receiver and sender
  flit_t      exp_flits [NODES][NODES][$];
  dbg_event_t exp_evts [NODES][$];
  logic       in_pkt [NODES];
  node_id_t   cur_src [NODES];

  int errors;
  int checks;
  int timeouts;
  int sent_flits;
  int rcvd_flits;
  int sent_pkts;
  int rcvd_evts;
  bit bp_on;

  mpsoc_top i_mpsoc_top (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .inj_valid_i (inj_valid),
    .inj_dest_i  (inj_dest),
    .inj_data_i  (inj_data),
    .inj_last_i  (inj_last),
    .inj_ready_o (inj_ready),
    .rx_valid_o  (rx_valid),
    .rx_src_o    (rx_src),
    .rx_data_o   (rx_data),
    .rx_last_o   (rx_last),
    .rx_ready_i  (rx_ready),
    .dbg_valid_o (dbg_valid),
    .dbg_event_o (dbg_event),
    .dbg_ready_i (dbg_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    errors++;
    $display("Timeout: %s", what);
  endtask

  function automatic int pending_items();
    int total;
    total = 0;
    for (int d = 0; d < NODES; d++) begin
      total += exp_evts[d].size();
      for (int s = 0; s < NODES; s++) begin
        total += exp_flits[d][s].size();
      end
    end
    return total;
  endfunction

  task automatic send_packet(input int n, input node_id_t dest, input int len);
    flit_t      f;
    dbg_event_t ev;
    logic       accepted;
    int         cyc;
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      f.dest       = dest;
      f.src        = node_id_t'(n);
      f.last       = (i == len - 1);
      f.data       = $urandom;
      inj_valid[n] = 1'b1;
      inj_dest[n]  = dest;
      inj_data[n]  = f.data;
      inj_last[n]  = f.last;
      accepted     = 1'b0;
      cyc          = 0;
      while (!accepted && cyc < TIMEOUT_CYCLES) begin
        @(posedge clk);
        accepted = inj_ready[n];
        cyc++;
      end
      if (!accepted) begin
        report_timeout($sformatf("tile %0d injection port never became ready", n));
        @(negedge clk);
        inj_valid[n] = 1'b0;
        return;
      end
      exp_flits[dest][n].push_back(f);
      sent_flits++;
    end
    ev.src  = node_id_t'(n);
    ev.dest = dest;
    ev.len  = 4'(len);
    exp_evts[n].push_back(ev);
    sent_pkts++;
    @(negedge clk);
    inj_valid[n] = 1'b0;
  endtask

  task automatic run_sender(input int n);
    int gap;
    for (int p = 0; p < NUM_PKTS && timeouts == 0; p++) begin
      send_packet(n, node_id_t'($urandom), 1 + ($urandom % MAX_LEN));
      gap = $urandom % 3;
      repeat (gap) @(negedge clk);
    end
  endtask

  task automatic drive_stalls();
    while (bp_on) begin
      @(negedge clk);
      rx_ready  = NODES'($urandom);
      dbg_ready = ($urandom % 4) != 0;
    end
    @(negedge clk);
    rx_ready  = '1;
    dbg_ready = 1'b1;
  endtask

  task automatic drain_model();
    int cyc;
    cyc = 0;
    while (pending_items() != 0 && cyc < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cyc++;
    end
    if (pending_items() != 0) begin
      report_timeout($sformatf("%0d flits or events never arrived", pending_items()));
    end
  endtask

  task automatic run_traffic(input bit stalls, input string name);
    int err0;
    int sf0;
    int rf0;
    err0  = errors;
    sf0   = sent_flits;
    rf0   = rcvd_flits;
    bp_on = stalls;
    fork
      drive_stalls();
      begin
        for (int n = 0; n < NODES; n++) begin
          automatic int k = n;
          fork
            run_sender(k);
          join_none
        end
        wait fork;
        bp_on = 1'b0;
      end
    join
    drain_model();
    check_value("received flits", rcvd_flits - rf0, sent_flits - sf0);
    $display("Test %s: %0d flits, %0d errors", name, sent_flits - sf0, errors - err0);
  endtask

  // Receivers, checked against the model
  always @(posedge clk) begin : rx_monitor
    flit_t    exp;
    node_id_t s;
    if (rst_n) begin
      for (int d = 0; d < NODES; d++) begin
        if (rx_valid[d] && rx_ready[d]) begin
          s = rx_src[d];
          rcvd_flits++;
          if (in_pkt[d] && s != cur_src[d]) begin
            check_value($sformatf("rx_src_o[%0d]", d), s, cur_src[d]);  // Interleaved
          end
          if (exp_flits[d][s].size() == 0) begin
            errors++;
            $display("Tile %0d received a flit from tile %0d that was never sent", d, s);
          end else begin
            exp = exp_flits[d][s].pop_front();
            check_value($sformatf("rx_data_o[%0d]", d), rx_data[d], exp.data);
            check_value($sformatf("rx_last_o[%0d]", d), rx_last[d], exp.last);
          end
          in_pkt[d]  = !rx_last[d];
          cur_src[d] = s;
        end
      end
    end
  end

  always @(posedge clk) begin : evt_monitor
    dbg_event_t exp;
    if (rst_n && dbg_valid && dbg_ready) begin
      rcvd_evts++;
      if (exp_evts[dbg_event.src].size() == 0) begin
        errors++;
        $display("Debug event from tile %0d with no packet sent", dbg_event.src);
      end else begin
        exp = exp_evts[dbg_event.src].pop_front();
        check_value("dbg_event_o", dbg_event, exp);
      end
    end
  end

  initial begin : main
    int err0;
    void'($urandom(32'h950c));
    rst_n     = 1'b0;
    inj_valid = '0;
    inj_dest  = '0;
    inj_data  = '0;
    inj_last  = '0;
    rx_ready  = '1;
    dbg_ready = 1'b1;
    bp_on     = 1'b0;
    for (int d = 0; d < NODES; d++) begin
      in_pkt[d]  = 1'b0;
      cur_src[d] = '0;
    end
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    err0 = errors;
    @(posedge clk);
    check_value("rx_valid_o", rx_valid, '0);
    check_value("dbg_valid_o", dbg_valid, 1'b0);
    check_value("inj_ready_o", inj_ready, {NODES{1'b1}});
    $display("Test reset: %0d errors", errors - err0);

    err0 = errors;
    send_packet(1, 2'd3, 3);  // Source, data and last come from the model
    drain_model();
    $display("Test single packet: %0d errors", errors - err0);

    run_traffic(1'b0, "random traffic");
    run_traffic(1'b1, "back-pressure");

    err0 = errors;
    check_value("debug events", rcvd_evts, sent_pkts);
    $display("Test debug events: %0d events, %0d errors", rcvd_evts, errors - err0);

    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* mpsoc.f */
+incdir+verilog
verilog/mpsoc_pkg.sv
verilog/flit_fifo.sv
verilog/noc_tile.sv
verilog/noc_link_arbiter.sv
verilog/mpsoc_top.sv
tb/tb_mpsoc.sv
